//--- hdl/frv_pkg.sv
/*
 * Shared definitions for the four stage RV32 integer pipeline.
 * Data widths, major opcodes, the micro-op set, the instruction word
 * views and the records passed between the stages.
 */
`default_nettype none

package frv_pkg;

    localparam int unsigned XLEN   = 32;                        // Data path width
    localparam int unsigned REG_AW = 5;                         // GPR address width
    localparam logic [XLEN-1:0] FRV_PC_RESET_VALUE = 32'h8000_0000; // PC out of reset

    // Major opcodes understood by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;             // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;             // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,                                 // Arithmetic and logic
        SLT, SLTU,                                              // Set less than
        SLL, SRL, SRA,                                          // Shifts
        LUI,
        BEQ, BNE,                                               // Conditional branches
        NOP                                                     // Retires, writes nothing
    } uop_e;

    // One instruction word, seen through the encoding formats
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r_view;
        struct packed {
            logic [11:0]       imm12;                           // Also holds the shamt
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i_view;
        struct packed {
            logic              imm_12;                          // Sign bit of the offset
            logic [5:0]        imm_10_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [3:0]        imm_4_1;
            logic              imm_11;
            logic [6:0]        opcode;
        } b_view;
    } instr_u;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        instr_u            instr;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
        logic [REG_AW-1:0] rd;                                  // Zero if nothing written
        uop_e              uop;
        logic [XLEN-1:0]   opr_a;
        logic [XLEN-1:0]   opr_b;
        logic [XLEN-1:0]   opr_c;                               // Branch offset
    } decode_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
        logic [REG_AW-1:0] rd;                                  // Zero if nothing written
        logic [XLEN-1:0]   wdata;
        logic              cf_taken;                            // Taken branch
        logic [XLEN-1:0]   cf_target;
    } result_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;                                  // Zero means no forward
        logic [XLEN-1:0]   wdata;
    } fwd_t;

endpackage

`default_nettype wire

//--- hdl/frv_fetch.sv
/*
 * Fetch stage. Holds the program counter, presents it to the
 * instruction memory and registers each granted word for decode.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_fetch (
    input  logic                     g_clk,
    input  logic                     arst_n,
    input  logic                     cf_req,         // Redirect from writeback
    input  logic [frv_pkg::XLEN-1:0] cf_target,      // Redirect destination
    output logic [frv_pkg::XLEN-1:0] imem_addr,      // Word being fetched
    input  logic                     imem_gnt,       // Word returned this cycle
    input  logic [frv_pkg::XLEN-1:0] imem_rdata,
    output frv_pkg::fetch_t          s1              // To decode
);
    import frv_pkg::*;

    logic [XLEN-1:0] pc;                             // Address of next fetch

    assign imem_addr = pc;

    // --------------------------------------------------------------------------
    // Program counter
    // --------------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= FRV_PC_RESET_VALUE;
        end else if (cf_req) begin
            pc <= cf_target;                         // Redirect wins over a grant
        end else if (imem_gnt) begin
            pc <= pc + XLEN'(4);
        end
    end

    // --------------------------------------------------------------------------
    // Fetch register
    // --------------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1 <= '0;
        end else begin
            s1.valid <= imem_gnt && !cf_req;         // Word granted under a redirect is dropped
            s1.pc    <= pc;
            s1.instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/frv_decode.sv
/*
 * Decode stage. Turns the fetched word into a micro-op with its
 * operands, resolves source hazards by forwarding from execute and
 * writeback, and registers the result for execute.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_decode (
    input  logic                       g_clk,
    input  logic                       arst_n,
    input  frv_pkg::fetch_t            s1,           // From fetch
    input  logic                       flush,        // Control flow change
    output logic [frv_pkg::REG_AW-1:0] rs1_addr,     // GPR read ports
    output logic [frv_pkg::REG_AW-1:0] rs2_addr,
    input  logic [frv_pkg::XLEN-1:0]   rs1_rdata,
    input  logic [frv_pkg::XLEN-1:0]   rs2_rdata,
    input  frv_pkg::fwd_t              fwd_ex,       // Result of the item in execute
    input  frv_pkg::fwd_t              fwd_wb,       // Item retiring this cycle
    output frv_pkg::decode_t           s2            // To execute
);
    import frv_pkg::*;

    uop_e              dec_uop;
    logic [REG_AW-1:0] dec_rd;
    logic              use_imm;                      // Operand B from imm12
    logic              op_reg;                       // Register-register form
    logic              f7_zero;
    logic              f7_alt;                       // SUB / SRA marker
    logic              enc_ok;                       // funct7 legal for this form
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   dec_opr_b;

    // Newest value of a source register, x0 reads zero
    function automatic logic [XLEN-1:0] pick_src(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   rdata,
        input fwd_t              ex,
        input fwd_t              wb
    );
        if (addr == '0) begin
            return '0;
        end else if (addr == ex.rd) begin
            return ex.wdata;                         // One instruction ahead
        end else if (addr == wb.rd) begin
            return wb.wdata;                         // GPR write still pending
        end
        return rdata;
    endfunction

    assign rs1_addr = s1.instr.r_view.rs1;
    assign rs2_addr = s1.instr.r_view.rs2;

    // --------------------------------------------------------------------------
    // Immediates
    // --------------------------------------------------------------------------

    assign imm_i = {{20{s1.instr.i_view.imm12[11]}}, s1.instr.i_view.imm12};
    assign imm_b = {{19{s1.instr.b_view.imm_12}}, s1.instr.b_view.imm_12,
                    s1.instr.b_view.imm_11, s1.instr.b_view.imm_10_5,
                    s1.instr.b_view.imm_4_1, 1'b0};
    assign imm_u = {s1.instr[31:12], 12'b0};         // LUI upper immediate

    // --------------------------------------------------------------------------
    // Micro-op selection
    // --------------------------------------------------------------------------

    assign op_reg  = s1.instr.r_view.opcode == OPC_OP;
    assign f7_zero = s1.instr.r_view.funct7 == 7'b0000000;
    assign f7_alt  = s1.instr.r_view.funct7 == 7'b0100000;
    assign enc_ok  = f7_zero || (f7_alt && (s1.instr.r_view.funct3 == 3'b101 ||
                                            (op_reg && s1.instr.r_view.funct3 == 3'b000)));

    always_comb begin
        dec_uop = NOP;
        use_imm = 1'b0;
        case (s1.instr.r_view.opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_imm = !op_reg;
                case (s1.instr.r_view.funct3)
                    3'b000:  dec_uop = (op_reg && f7_alt) ? SUB : ADD;
                    3'b001:  dec_uop = SLL;
                    3'b010:  dec_uop = SLT;
                    3'b011:  dec_uop = SLTU;
                    3'b100:  dec_uop = XOR;
                    3'b101:  dec_uop = f7_alt ? SRA : SRL;
                    3'b110:  dec_uop = OR;
                    default: dec_uop = AND;
                endcase
                // funct7 only matters for R forms and immediate shifts
                if (!enc_ok && (op_reg || s1.instr.r_view.funct3[1:0] == 2'b01)) begin
                    dec_uop = NOP;
                end
            end
            OPC_LUI:    dec_uop = LUI;
            OPC_BRANCH: begin
                if (s1.instr.b_view.funct3 == 3'b000) begin
                    dec_uop = BEQ;
                end else if (s1.instr.b_view.funct3 == 3'b001) begin
                    dec_uop = BNE;
                end
            end
            default:    dec_uop = NOP;
        endcase
    end

    // Branches and no-ops never write a register
    assign dec_rd = (dec_uop == NOP || dec_uop == BEQ || dec_uop == BNE) ?
                    '0 : s1.instr.r_view.rd;

    // --------------------------------------------------------------------------
    // Operands and the decode register
    // --------------------------------------------------------------------------

    assign rs1_val   = pick_src(rs1_addr, rs1_rdata, fwd_ex, fwd_wb);
    assign rs2_val   = pick_src(rs2_addr, rs2_rdata, fwd_ex, fwd_wb);
    assign dec_opr_b = (dec_uop == LUI) ? imm_u : use_imm ? imm_i : rs2_val;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s2 <= '0;
        end else begin
            s2.valid <= s1.valid && !flush;
            s2.pc    <= s1.pc;
            s2.instr <= s1.instr;
            s2.rd    <= dec_rd;
            s2.uop   <= dec_uop;
            s2.opr_a <= rs1_val;
            s2.opr_b <= dec_opr_b;
            s2.opr_c <= imm_b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/frv_execute.sv
/*
 * Execute stage. ALU, branch compare and branch target, with the
 * result forwarded back to decode and registered for writeback.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_execute (
    input  logic              g_clk,
    input  logic              arst_n,
    input  frv_pkg::decode_t  s2,                    // From decode
    input  logic              flush,                 // Control flow change
    output frv_pkg::fwd_t     fwd_ex,                // Result for decode
    output frv_pkg::result_t  s3                     // To writeback
);
    import frv_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [4:0]      shamt;
    logic            opr_eq;
    logic            taken;

    assign shamt  = s2.opr_b[4:0];                   // Shift amount, low 5 bits
    assign opr_eq = s2.opr_a == s2.opr_b;
    assign taken  = (s2.uop == BEQ && opr_eq) || (s2.uop == BNE && !opr_eq);

    // --------------------------------------------------------------------------
    // ALU
    // --------------------------------------------------------------------------

    always_comb begin
        case (s2.uop)
            ADD:     alu_result = s2.opr_a + s2.opr_b;
            SUB:     alu_result = s2.opr_a - s2.opr_b;
            AND:     alu_result = s2.opr_a & s2.opr_b;
            OR:      alu_result = s2.opr_a | s2.opr_b;
            XOR:     alu_result = s2.opr_a ^ s2.opr_b;
            SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(s2.opr_a) < $signed(s2.opr_b)};
            SLTU:    alu_result = {{(XLEN-1){1'b0}}, s2.opr_a < s2.opr_b};
            SLL:     alu_result = s2.opr_a << shamt;
            SRL:     alu_result = s2.opr_a >> shamt;
            SRA:     alu_result = $unsigned($signed(s2.opr_a) >>> shamt);
            LUI:     alu_result = s2.opr_b;          // Immediate already shifted up
            default: alu_result = '0;                // Branches and no-ops
        endcase
    end

    // Only a valid item may forward
    assign fwd_ex.rd    = s2.valid ? s2.rd : '0;
    assign fwd_ex.wdata = alu_result;

    // --------------------------------------------------------------------------
    // Execute register
    // --------------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s3 <= '0;
        end else begin
            s3.valid     <= s2.valid && !flush;
            s3.pc        <= s2.pc;
            s3.instr     <= s2.instr;
            s3.rd        <= s2.rd;
            s3.wdata     <= alu_result;
            s3.cf_taken  <= taken;
            s3.cf_target <= s2.pc + s2.opr_c;        // Branch target
        end
    end

endmodule

`default_nettype wire

//--- hdl/frv_writeback.sv
/*
 * Writeback stage. Retires the item in s3: GPR write, trace outputs
 * and the control flow change request for a taken branch.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_writeback (
    input  frv_pkg::result_t           s3,           // From execute
    output frv_pkg::fwd_t              fwd_wb,       // Retiring result for decode
    output logic                       gpr_wen,
    output logic [frv_pkg::REG_AW-1:0] gpr_rd,
    output logic [frv_pkg::XLEN-1:0]   gpr_wdata,
    output logic                       cf_req,       // One-cycle redirect pulse
    output logic [frv_pkg::XLEN-1:0]   cf_target,
    output logic                       trs_valid,    // Instruction retired
    output logic [frv_pkg::XLEN-1:0]   trs_pc,
    output logic [frv_pkg::XLEN-1:0]   trs_instr,
    output logic [frv_pkg::REG_AW-1:0] trs_rd,       // Zero if nothing written
    output logic [frv_pkg::XLEN-1:0]   trs_wdata
);
    import frv_pkg::*;

    logic rd_live;                                   // Valid item with a real rd

    assign rd_live = s3.valid && (s3.rd != '0);

    assign fwd_wb.rd    = rd_live ? s3.rd : '0;
    assign fwd_wb.wdata = s3.wdata;

    // GPR port, written at the end of this cycle
    assign gpr_wen   = rd_live;
    assign gpr_rd    = s3.rd;
    assign gpr_wdata = s3.wdata;

    assign cf_req    = s3.valid && s3.cf_taken;
    assign cf_target = s3.cf_target;

    // Trace
    assign trs_valid = s3.valid;
    assign trs_pc    = s3.pc;
    assign trs_instr = s3.instr;
    assign trs_rd    = rd_live ? s3.rd : '0;
    assign trs_wdata = rd_live ? s3.wdata : '0;

endmodule

`default_nettype wire

//--- hdl/frv_gprs.sv
/*
 * General purpose register file. 31 storage registers, two
 * combinational read ports and one write port, x0 reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_gprs (
    input  logic                       g_clk,
    input  logic                       arst_n,
    input  logic [frv_pkg::REG_AW-1:0] rs1_addr,
    input  logic [frv_pkg::REG_AW-1:0] rs2_addr,
    output logic [frv_pkg::XLEN-1:0]   rs1_rdata,
    output logic [frv_pkg::XLEN-1:0]   rs2_rdata,
    input  logic                       rd_wen,
    input  logic [frv_pkg::REG_AW-1:0] rd_addr,
    input  logic [frv_pkg::XLEN-1:0]   rd_wdata
);
    import frv_pkg::*;

    logic [XLEN-1:0] regs [1:2**REG_AW-1];           // No storage behind x0

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    // Reads see the old value during a write
    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- hdl/frv_pipeline.sv
/*
 * Top level of the four stage RV32 integer pipeline.
 * Connects fetch, decode, execute, writeback and the register file.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_pipeline (
    input  logic                       g_clk,
    input  logic                       arst_n,
    output logic [frv_pkg::XLEN-1:0]   imem_addr,    // Fetch address
    input  logic                       imem_gnt,     // Word valid this cycle
    input  logic [frv_pkg::XLEN-1:0]   imem_rdata,
    output logic                       trs_valid,    // Retirement trace
    output logic [frv_pkg::XLEN-1:0]   trs_pc,
    output logic [frv_pkg::XLEN-1:0]   trs_instr,
    output logic [frv_pkg::REG_AW-1:0] trs_rd,
    output logic [frv_pkg::XLEN-1:0]   trs_wdata
);
    import frv_pkg::*;

    fetch_t            s1;                           // Fetch to decode
    decode_t           s2;                           // Decode to execute
    result_t           s3;                           // Execute to writeback
    fwd_t              fwd_ex;
    fwd_t              fwd_wb;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_rdata;
    logic [XLEN-1:0]   rs2_rdata;
    logic              gpr_wen;
    logic [REG_AW-1:0] gpr_rd;
    logic [XLEN-1:0]   gpr_wdata;
    logic              cf_req;                       // Also flushes decode and execute
    logic [XLEN-1:0]   cf_target;

    // --------------------------------------------------------------------------
    // Stages
    // --------------------------------------------------------------------------

    frv_fetch i_fetch (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     ),
        .cf_req     (cf_req     ),
        .cf_target  (cf_target  ),
        .imem_addr  (imem_addr  ),
        .imem_gnt   (imem_gnt   ),
        .imem_rdata (imem_rdata ),
        .s1         (s1         )
    );

    frv_decode i_decode (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     ),
        .s1         (s1         ),
        .flush      (cf_req     ),
        .rs1_addr   (rs1_addr   ),
        .rs2_addr   (rs2_addr   ),
        .rs1_rdata  (rs1_rdata  ),
        .rs2_rdata  (rs2_rdata  ),
        .fwd_ex     (fwd_ex     ),
        .fwd_wb     (fwd_wb     ),
        .s2         (s2         )
    );

    frv_execute i_execute (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     ),
        .s2         (s2         ),
        .flush      (cf_req     ),
        .fwd_ex     (fwd_ex     ),
        .s3         (s3         )
    );

    frv_writeback i_writeback (
        .s3         (s3         ),
        .fwd_wb     (fwd_wb     ),
        .gpr_wen    (gpr_wen    ),
        .gpr_rd     (gpr_rd     ),
        .gpr_wdata  (gpr_wdata  ),
        .cf_req     (cf_req     ),
        .cf_target  (cf_target  ),
        .trs_valid  (trs_valid  ),
        .trs_pc     (trs_pc     ),
        .trs_instr  (trs_instr  ),
        .trs_rd     (trs_rd     ),
        .trs_wdata  (trs_wdata  )
    );

    // --------------------------------------------------------------------------
    // Register file
    // --------------------------------------------------------------------------

    frv_gprs i_gprs (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     ),
        .rs1_addr   (rs1_addr   ),
        .rs2_addr   (rs2_addr   ),
        .rs1_rdata  (rs1_rdata  ),
        .rs2_rdata  (rs2_rdata  ),
        .rd_wen     (gpr_wen    ),
        .rd_addr    (gpr_rd     ),
        .rd_wdata   (gpr_wdata  )
    );

endmodule

`default_nettype wire

//--- verif/frv_tb_clk.sv
/*
 * Testbench clock and reset generator.
 * 10 ns clock, reset held low over the first four rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_tb_clk (
    output logic g_clk,
    output logic arst_n
);
    localparam int HALF_PERIOD  = 5;                 // 10 ns period
    localparam int RESET_CYCLES = 4;

    initial begin
        g_clk = 1'b0;
        forever #HALF_PERIOD g_clk = ~g_clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1 arst_n = 1'b1;                            // Released just after the edge
    end

endmodule

`default_nettype wire

//--- verif/frv_pipeline_props.sv
/*
 * Interface properties of the pipeline top level.
 * Reset behaviour, trace hygiene and the fetch address protocol.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_pipeline_props (
    input  logic                       g_clk,
    input  logic                       arst_n,
    input  logic [frv_pkg::XLEN-1:0]   imem_addr,
    input  logic                       imem_gnt,
    input  logic                       cf_req,       // Internal redirect pulse
    input  logic                       trs_valid,
    input  logic [frv_pkg::REG_AW-1:0] trs_rd
);

    // Nothing retires or redirects while reset is held
    reset_quiet: assert property (@(posedge g_clk) !arst_n |-> !trs_valid && !cf_req)
        else $error("retirement or redirect seen during reset");

    idle_rd_zero: assert property (@(posedge g_clk) disable iff (!arst_n)
        !trs_valid |-> trs_rd == '0)
        else $error("trace destination nonzero without a retirement");

    addr_aligned: assert property (@(posedge g_clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    // Address moves only on a grant or a redirect
    addr_held: assert property (@(posedge g_clk) disable iff (!arst_n)
        !imem_gnt && !cf_req |=> $stable(imem_addr))
        else $error("instruction address changed without grant or redirect");

endmodule

bind frv_pipeline frv_pipeline_props props (
    .g_clk      (g_clk      ),
    .arst_n     (arst_n     ),
    .imem_addr  (imem_addr  ),
    .imem_gnt   (imem_gnt   ),
    .cf_req     (cf_req     ),
    .trs_valid  (trs_valid  ),
    .trs_rd     (trs_rd     )
);

`default_nettype wire

//--- verif/frv_pipeline_tb.sv
/*
 * Testbench for the four stage RV32 pipeline. Builds a random program,
 * models the instruction memory with random grants and checks each
 * retirement against an architectural reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module frv_pipeline_tb;
    import frv_pkg::*;

    localparam int PROG_WORDS  = 256;                // Random program length
    localparam int N_RETIRE    = 400;                // Retirements for a pass
    localparam int CYCLE_LIMIT = N_RETIRE * 10;      // Room for stalls and flushes

    typedef struct packed {
        logic [REG_AW-1:0] rd;                       // Zero if nothing written
        logic [XLEN-1:0]   wdata;
        logic [XLEN-1:0]   next_pc;
    } step_t;

    logic              g_clk;
    logic              arst_n;
    logic [XLEN-1:0]   imem_addr;
    logic              imem_gnt;
    logic [XLEN-1:0]   imem_rdata;
    logic              trs_valid;
    logic [XLEN-1:0]   trs_pc;
    logic [XLEN-1:0]   trs_instr;
    logic [REG_AW-1:0] trs_rd;
    logic [XLEN-1:0]   trs_wdata;

    integer            seed = 32'h9114;
    logic [XLEN-1:0]   prog      [0:PROG_WORDS-1];
    logic [XLEN-1:0]   arch_regs [0:31];            // Architectural GPRs
    logic [XLEN-1:0]   ref_pc;
    int                retired;
    int                cycles;

    frv_tb_clk clk_gen (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     )
    );

    frv_pipeline uut (
        .g_clk      (g_clk      ),
        .arst_n     (arst_n     ),
        .imem_addr  (imem_addr  ),
        .imem_gnt   (imem_gnt   ),
        .imem_rdata (imem_rdata ),
        .trs_valid  (trs_valid  ),
        .trs_pc     (trs_pc     ),
        .trs_instr  (trs_instr  ),
        .trs_rd     (trs_rd     ),
        .trs_wdata  (trs_wdata  )
    );

    // --------------------------------------------------------------------------
    // Program and memory model
    // --------------------------------------------------------------------------

    // ADDI x0 no-op whose immediate folds in every address bit
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        logic [11:0] imm;
        imm = addr[13:2] ^ addr[25:14] ^ {4'b0, addr[31:26], addr[1:0]};
        return {imm, 5'd0, 3'b000, 5'd0, 7'h13};
    endfunction

    function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offs;
        offs = addr - FRV_PC_RESET_VALUE;
        if (offs < XLEN'(PROG_WORDS * 4)) begin
            return prog[offs[9:2]];
        end
        return fill_word(addr);                      // Beyond the program
    endfunction

    // Supported instructions only on registers x0 to x7
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [12:0] boff;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r   = $random(seed);
            v   = $random(seed);
            rd  = {2'b00, r[2:0]};
            rs1 = {2'b00, r[5:3]};
            rs2 = {2'b00, r[8:6]};
            f3  = r[11:9];
            case (r[14:12])
                3'd0, 3'd1, 3'd2: begin              // Register-register forms
                    prog[i[7:0]] = {1'b0, r[15] && (f3 == 3'b000 || f3 == 3'b101),
                                    5'b0, rs2, rs1, f3, rd, 7'h33};
                end
                3'd3, 3'd4, 3'd5: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        v[31:25] = {1'b0, r[15] && f3 == 3'b101, 5'b0};  // Shamt in v[24:20]
                    end
                    prog[i[7:0]] = {v[31:20], rs1, f3, rd, 7'h13};
                end
                3'd6:    prog[i[7:0]] = {v[31:20], v[19:12], rd, 7'h37};  // LUI
                default: begin                       // Forward BEQ or BNE
                    boff = 13'((int'(v[7:0]) % 7 + 2) * 4);
                    prog[i[7:0]] = {boff[12], boff[10:5], rs2, rs1, 2'b00, r[15],
                                    boff[4:1], boff[11], 7'h63};
                end
            endcase
        end
    endtask

    // Grant and data a small delay after the rising edge
    initial begin : memory_model
        logic [XLEN-1:0] r;
        imem_gnt   = 1'b0;
        imem_rdata = '0;
        build_program();
        forever begin
            @(posedge g_clk);
            #1;
            r        = $random(seed);
            imem_gnt = r[1:0] != 2'b00;              // About 75% grants
            if (imem_gnt) begin
                imem_rdata = mem_word(imem_addr);
            end else begin
                imem_rdata = $random(seed);          // Junk must never be fetched
            end
        end
    end

    // --------------------------------------------------------------------------
    // Reference model
    // --------------------------------------------------------------------------

    // One ALU operation as the ISA defines it
    function automatic logic [XLEN-1:0] alu_value(
        input logic [2:0]      f3,
        input logic            alt,                  // SUB or SRA
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic step_t expected_step(input logic [XLEN-1:0] pc,
                                            input logic [XLEN-1:0] word);
        step_t           s;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] boff;
        logic [2:0]      f3;
        logic            legal;
        a         = arch_regs[word[19:15]];
        b         = arch_regs[word[24:20]];
        f3        = word[14:12];
        imm       = {{20{word[31]}}, word[31:20]};
        boff      = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        s.rd      = '0;
        s.wdata   = '0;
        s.next_pc = pc + 32'd4;
        case (word[6:0])
            7'h33: begin
                legal = word[31:25] == 7'h00 ||
                        (word[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                if (legal) begin
                    s.rd    = word[11:7];
                    s.wdata = alu_value(f3, word[30], a, b);
                end
            end
            7'h13: begin                             // funct7 only checked on shifts
                legal = f3[1:0] != 2'b01 || word[31:25] == 7'h00 ||
                        (word[31:25] == 7'h20 && f3 == 3'b101);
                if (legal) begin
                    s.rd    = word[11:7];
                    s.wdata = alu_value(f3, f3 == 3'b101 && word[30], a, imm);
                end
            end
            7'h37: begin
                s.rd    = word[11:7];
                s.wdata = {word[31:12], 12'b0};
            end
            7'h63: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    s.next_pc = pc + boff;           // Taken
                end
            end
            default: begin
            end
        endcase
        if (s.rd == '0) begin
            s.wdata = '0;                            // x0 write is discarded
        end
        return s;
    endfunction

    // --------------------------------------------------------------------------
    // Compare and timeout
    // --------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("error: %s is 0x%08h, expected 0x%08h at retirement %0d",
                     name, got, want, retired);
            $display("TEST RESULT: FAIL");
            $fatal(1, "retirement trace differs from the reference");
        end
    endtask

    initial begin : compare
        step_t           ref_step;
        logic [XLEN-1:0] word;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i[4:0]] = '0;
        end
        ref_pc  = FRV_PC_RESET_VALUE;
        retired = 0;
        @(posedge arst_n);
        while (retired < N_RETIRE) begin
            @(negedge g_clk);                        // Trace is stable mid-cycle
            if (trs_valid) begin
                word     = mem_word(ref_pc);
                ref_step = expected_step(ref_pc, word);
                check_value("trs_pc", trs_pc, ref_pc);
                check_value("trs_instr", trs_instr, word);
                check_value("trs_rd", XLEN'(trs_rd), XLEN'(ref_step.rd));
                check_value("trs_wdata", trs_wdata, ref_step.wdata);
                if (ref_step.rd != '0) begin
                    arch_regs[ref_step.rd] = ref_step.wdata;
                end
                ref_pc  = ref_step.next_pc;
                retired = retired + 1;
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge g_clk);
            cycles = cycles + 1;
        end
        $display("timeout: only %0d of %0d instructions retired within %0d cycles",
                 retired, N_RETIRE, cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the cycle limit");
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/frv_pkg.sv
hdl/frv_fetch.sv
hdl/frv_decode.sv
hdl/frv_execute.sv
hdl/frv_writeback.sv
hdl/frv_gprs.sv
hdl/frv_pipeline.sv
verif/frv_tb_clk.sv
verif/frv_pipeline_props.sv
verif/frv_pipeline_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module frv_pipeline_tb -Mdir obj_dir -o frv_pipeline_sim -f sim.f

./obj_dir/frv_pipeline_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
